// File: common/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [31:0] u32_t;

    // CSR numbers kept by this unit
    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    typedef struct packed {
        logic [26:0] r0;    // datf/datm not modelled
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] r0;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    typedef struct packed {
        logic        r0_2;
        logic [8:0]  esubcode;
        logic [5:0]  ecode;     // 21:16
        logic [2:0]  r0_1;
        logic [12:0] is;        // Pending interrupt bits
    } estat_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    // Registers visible to the exception controller
    typedef struct packed {
        crmd_t       crmd;
        prmd_t       prmd;
        logic [12:0] lie;
        estat_t      estat;
        u32_t        era;
        u32_t        eentry;
    } csr_state_t;

    localparam crmd_t CRMD_RESET = '{r0: '0, pg: 1'b0, da: 1'b1, ie: 1'b0, plv: 2'b00};
    localparam int    TI_BIT     = 11;

    // Writable field masks
    localparam u32_t CRMD_WMASK   = 32'h0000_001f;
    localparam u32_t PRMD_WMASK   = 32'h0000_0007;
    localparam u32_t ECFG_WMASK   = 32'h0000_1bff;   // Bit 10 reserved
    localparam u32_t EENTRY_WMASK = 32'hffff_ffc0;

endpackage

`default_nettype wire

// File: common/excp_pkg.sv
`default_nettype none

package excp_pkg;

    typedef enum logic [5:0] {
        ECODE_INT  = 6'h00,
        ECODE_ADEF = 6'h08,
        ECODE_SYS  = 6'h0b,
        ECODE_BRK  = 6'h0c,
        ECODE_INE  = 6'h0d
    } ecode_e;

    // CSR instruction access, one-cycle strobe
    typedef struct packed {
        logic                 we;
        csr_pkg::csr_addr_e   addr;
        csr_pkg::u32_t        wr_data;
    } csr_op_t;

    // Controller update of the register file
    typedef struct packed {
        logic                 enter;
        logic                 ret;
        ecode_e               ecode;
        logic [1:0]           save_plv;   // Goes to PRMD on entry
        logic                 save_ie;
        csr_pkg::u32_t        era;
        csr_pkg::u32_t        badv;
    } excp_wr_req_t;

    typedef struct packed {
        logic                 valid;
        csr_pkg::u32_t        pc;
        logic                 excp_valid;
        ecode_e               excp_code;
        csr_pkg::u32_t        badv;
        logic                 is_ertn;
    } commit_t;

endpackage

`default_nettype wire

// File: csr/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire excp_pkg::csr_op_t csr_op,
    input  wire csr_pkg::csr_addr_e rd_addr,
    input  wire [7:0]              hw_int,
    input  wire                    ti_fire,
    input  wire csr_pkg::u32_t     tval,
    input  wire excp_pkg::excp_wr_req_t excp_wr_req,
    output csr_pkg::u32_t          rd_data,
    output csr_pkg::csr_state_t    state,
    output logic                   tcfg_we,
    output csr_pkg::u32_t          tcfg_data
);

    csr_pkg::crmd_t  crmd;
    csr_pkg::prmd_t  prmd;
    csr_pkg::estat_t estat;
    logic [12:0]     lie;
    logic [12:0]     is_q;
    logic [5:0]      ecode;
    csr_pkg::u32_t   era;
    csr_pkg::u32_t   badv;
    csr_pkg::u32_t   eentry;
    csr_pkg::u32_t   save [4];
    csr_pkg::u32_t   tid;
    csr_pkg::u32_t   tcfg;      // Readback copy, timer keeps its own
    logic            csr_we;
    logic            ticlr;

    // Controller request wins over the instruction write
    assign csr_we = csr_op.we && !excp_wr_req.enter && !excp_wr_req.ret;
    assign ticlr  = csr_we && (csr_op.addr == csr_pkg::CSR_TICLR) && csr_op.wr_data[0];

    assign tcfg_we   = csr_we && (csr_op.addr == csr_pkg::CSR_TCFG);
    assign tcfg_data = csr_op.wr_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd   <= csr_pkg::CRMD_RESET;
            prmd   <= '0;
            lie    <= '0;
            ecode  <= '0;
            era    <= '0;
            badv   <= '0;
            eentry <= '0;
            save   <= '{default: '0};
            tid    <= '0;
            tcfg   <= '0;
        end else if (excp_wr_req.enter) begin
            prmd.pplv <= excp_wr_req.save_plv;
            prmd.pie  <= excp_wr_req.save_ie;
            crmd.plv  <= 2'b00;     // Handler runs at PLV0 with interrupts off
            crmd.ie   <= 1'b0;
            era       <= excp_wr_req.era;
            ecode     <= excp_wr_req.ecode;
            if (excp_wr_req.ecode == excp_pkg::ECODE_ADEF) begin
                badv <= excp_wr_req.badv;
            end
        end else if (excp_wr_req.ret) begin
            crmd.plv <= prmd.pplv;
            crmd.ie  <= prmd.pie;
        end else if (csr_we) begin
            case (csr_op.addr)
                csr_pkg::CSR_CRMD:   crmd <= csr_pkg::crmd_t'(csr_op.wr_data & csr_pkg::CRMD_WMASK);
                csr_pkg::CSR_PRMD:   prmd <= csr_pkg::prmd_t'(csr_op.wr_data & csr_pkg::PRMD_WMASK);
                csr_pkg::CSR_ECFG:   lie  <= csr_op.wr_data[12:0] & csr_pkg::ECFG_WMASK[12:0];
                csr_pkg::CSR_ERA:    era  <= csr_op.wr_data;
                csr_pkg::CSR_BADV:   badv <= csr_op.wr_data;
                csr_pkg::CSR_EENTRY: eentry <= csr_op.wr_data & csr_pkg::EENTRY_WMASK;
                csr_pkg::CSR_SAVE0:  save[0] <= csr_op.wr_data;
                csr_pkg::CSR_SAVE1:  save[1] <= csr_op.wr_data;
                csr_pkg::CSR_SAVE2:  save[2] <= csr_op.wr_data;
                csr_pkg::CSR_SAVE3:  save[3] <= csr_op.wr_data;
                csr_pkg::CSR_TID:    tid  <= csr_op.wr_data;
                csr_pkg::CSR_TCFG:   tcfg <= csr_op.wr_data;
                default: ;  // ESTAT, TICLR handled with the pending bits
            endcase
        end
    end

    // Pending interrupt bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_q <= '0;
        end else begin
            if (csr_we && (csr_op.addr == csr_pkg::CSR_ESTAT)) begin
                is_q[1:0] <= csr_op.wr_data[1:0];   // Software interrupts
            end
            is_q[9:2] <= hw_int;
            if (ti_fire) begin
                is_q[csr_pkg::TI_BIT] <= 1'b1;      // Set beats TICLR
            end else if (ticlr) begin
                is_q[csr_pkg::TI_BIT] <= 1'b0;
            end
        end
    end

    assign estat = '{r0_2: 1'b0, esubcode: '0, ecode: ecode, r0_1: '0, is: is_q};

    assign state = '{
        crmd:   crmd,
        prmd:   prmd,
        lie:    lie,
        estat:  estat,
        era:    era,
        eentry: eentry
    };

    always_comb begin
        case (rd_addr)
            csr_pkg::CSR_CRMD:   rd_data = crmd;
            csr_pkg::CSR_PRMD:   rd_data = prmd;
            csr_pkg::CSR_ECFG:   rd_data = {19'b0, lie};
            csr_pkg::CSR_ESTAT:  rd_data = estat;
            csr_pkg::CSR_ERA:    rd_data = era;
            csr_pkg::CSR_BADV:   rd_data = badv;
            csr_pkg::CSR_EENTRY: rd_data = eentry;
            csr_pkg::CSR_SAVE0:  rd_data = save[0];
            csr_pkg::CSR_SAVE1:  rd_data = save[1];
            csr_pkg::CSR_SAVE2:  rd_data = save[2];
            csr_pkg::CSR_SAVE3:  rd_data = save[3];
            csr_pkg::CSR_TID:    rd_data = tid;
            csr_pkg::CSR_TCFG:   rd_data = tcfg;
            csr_pkg::CSR_TVAL:   rd_data = tval;
            default:             rd_data = '0;   // TICLR reads zero too
        endcase
    end

endmodule

`default_nettype wire

// File: csr/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                tcfg_we,
    input  wire csr_pkg::u32_t tcfg_data,
    output csr_pkg::u32_t      tval,
    output logic               ti_fire
);

    csr_pkg::tcfg_t cfg_in;
    logic           en;
    logic           periodic;
    logic [29:0]    initval;

    assign cfg_in = csr_pkg::tcfg_t'(tcfg_data);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en       <= 1'b0;
            periodic <= 1'b0;
            initval  <= '0;
            tval     <= '0;
        end else if (tcfg_we) begin
            en       <= cfg_in.en;
            periodic <= cfg_in.periodic;
            initval  <= cfg_in.initval;
            if (cfg_in.en) begin
                tval <= {cfg_in.initval, 2'b00};
            end
        end else if (en) begin
            if (tval == '0) begin
                if (periodic) begin
                    tval <= {initval, 2'b00};   // Reload and keep running
                end else begin
                    en   <= 1'b0;
                    tval <= '1;                 // One-shot parks at all ones
                end
            end else begin
                tval <= tval - 32'd1;
            end
        end
    end

    assign ti_fire = en && (tval == '0);

endmodule

`default_nettype wire

// File: project.f
common/csr_pkg.sv
common/excp_pkg.sv
csr/csr_timer.sv
csr/csr_file.sv
rtl/excp_ctrl.sv
rtl/csr_unit_top.sv
tb/csr_checker.sv
tb/tb_csr_unit.sv

// File: rtl/csr_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire excp_pkg::csr_op_t  csr_op,
    input  wire excp_pkg::commit_t  commit,
    input  wire [7:0]               hw_int,
    input  wire csr_pkg::csr_addr_e rd_addr,
    output csr_pkg::u32_t           rd_data,
    output logic                    redirect_valid,
    output csr_pkg::u32_t           redirect_pc
);

    csr_pkg::csr_state_t    state;
    excp_pkg::excp_wr_req_t excp_wr_req;
    logic                   tcfg_we;
    csr_pkg::u32_t          tcfg_data;
    csr_pkg::u32_t          tval;
    logic                   ti_fire;

    csr_file u_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_op      (csr_op),
        .rd_addr     (rd_addr),
        .hw_int      (hw_int),
        .ti_fire     (ti_fire),
        .tval        (tval),
        .excp_wr_req (excp_wr_req),
        .rd_data     (rd_data),
        .state       (state),
        .tcfg_we     (tcfg_we),
        .tcfg_data   (tcfg_data)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .tcfg_we   (tcfg_we),
        .tcfg_data (tcfg_data),
        .tval      (tval),
        .ti_fire   (ti_fire)
    );

    excp_ctrl u_excp (
        .clk            (clk),
        .rst_n          (rst_n),
        .commit         (commit),
        .state          (state),
        .excp_wr_req    (excp_wr_req),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// File: rtl/excp_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module excp_ctrl (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire excp_pkg::commit_t       commit,
    input  wire csr_pkg::csr_state_t     state,
    output excp_pkg::excp_wr_req_t       excp_wr_req,
    output logic                         redirect_valid,
    output csr_pkg::u32_t                redirect_pc
);

    logic int_pending;
    logic take_int;
    logic take_excp;
    logic take_ret;

    assign int_pending = state.crmd.ie && |(state.estat.is & state.lie);

    // Interrupt, then exception, then ERTN
    assign take_int  = commit.valid && int_pending;
    assign take_excp = commit.valid && !int_pending && commit.excp_valid;
    assign take_ret  = commit.valid && !int_pending && !commit.excp_valid && commit.is_ertn;

    always_comb begin
        excp_wr_req.enter    = take_int || take_excp;
        excp_wr_req.ret      = take_ret;
        excp_wr_req.ecode    = take_int ? excp_pkg::ECODE_INT : commit.excp_code;
        excp_wr_req.save_plv = state.crmd.plv;
        excp_wr_req.save_ie  = state.crmd.ie;
        excp_wr_req.era      = commit.pc;
        excp_wr_req.badv     = commit.badv;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= take_int || take_excp || take_ret;
        end
    end

    // Target sampled in the commit cycle, before the file updates
    always_ff @(posedge clk) begin
        redirect_pc <= take_ret ? state.era : state.eentry;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the CSR unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_csr_unit -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb/csr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module csr_checker (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire csr_pkg::csr_addr_e rd_addr,
    input  wire csr_pkg::u32_t      rd_data,
    input  wire                     redirect_valid,
    input  wire csr_pkg::u32_t      redirect_pc,
    input  wire                     chk_rd,      // Compare rd_data this cycle
    input  wire                     chk_redir,   // Redirect expected this cycle
    input  wire csr_pkg::u32_t      exp_val,
    input  wire csr_pkg::u32_t      exp_mask,
    output int                      errors
);

    int err_count = 0;

    assign errors = err_count;

    // Sampled mid-cycle where inputs and outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (chk_rd && ((rd_data & exp_mask) !== exp_val)) begin
                $display("ERR %0t rd_data[%h] expected %h actual %h",
                         $time, rd_addr, exp_val, rd_data & exp_mask);
                err_count = err_count + 1;
            end
            if (chk_redir && !redirect_valid) begin
                $display("Missing redirect at %0t, redirect_valid is low", $time);
                err_count = err_count + 1;
            end else if (chk_redir && (redirect_pc !== exp_val)) begin
                $display("ERR %0t redirect_pc expected %h actual %h",
                         $time, exp_val, redirect_pc);
                err_count = err_count + 1;
            end
            // Catches both stray redirects and pulses longer than one cycle
            if (!chk_redir && redirect_valid) begin
                $display("Unexpected redirect at %0t to pc %h", $time, redirect_pc);
                err_count = err_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

    typedef enum logic [2:0] {K_WRITE, K_READ, K_COMMIT, K_WAIT, K_HWINT} kind_e;

    typedef struct packed {
        kind_e            kind;
        logic [13:0]      addr;
        logic [31:0]      data;      // Write data, pc, tick count or hw_int
        logic [31:0]      mask;
        logic             excp_valid;
        excp_pkg::ecode_e code;
        logic             is_ertn;
        logic [31:0]      exp_val;
    } step_t;

    localparam int            REDIRECT_TIMEOUT = 4;
    localparam csr_pkg::u32_t ALL      = 32'hffff_ffff;
    localparam csr_pkg::u32_t CRMD_DA  = 32'h0000_0008;
    localparam csr_pkg::u32_t CRMD_IE  = 32'h0000_0004;
    localparam csr_pkg::u32_t PLV3     = 32'h0000_0003;
    localparam csr_pkg::u32_t ECODE_M  = 32'h003f_0000;   // ESTAT 21:16
    localparam csr_pkg::u32_t TI_M     = 32'h0000_0800;
    localparam csr_pkg::u32_t HANDLER  = 32'h1c00_8000;
    localparam csr_pkg::u32_t BAD_ADDR = 32'h0bad_0f0c;

    logic               clk;
    logic               rst_n;
    excp_pkg::csr_op_t  csr_op;
    excp_pkg::commit_t  commit;
    logic [7:0]         hw_int;
    csr_pkg::csr_addr_e rd_addr;
    csr_pkg::u32_t      rd_data;
    logic               redirect_valid;
    csr_pkg::u32_t      redirect_pc;
    logic               chk_rd;
    logic               chk_redir;
    csr_pkg::u32_t      exp_val;
    csr_pkg::u32_t      exp_mask;
    int                 errors;
    int                 timeouts;
    int                 late;
    step_t              steps[$];

    csr_unit_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .csr_op         (csr_op),
        .commit         (commit),
        .hw_int         (hw_int),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    csr_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .chk_rd         (chk_rd),
        .chk_redir      (chk_redir),
        .exp_val        (exp_val),
        .exp_mask       (exp_mask),
        .errors         (errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic csr_pkg::u32_t tcfg_word(input int initval, input bit periodic,
                                                input bit en);
        return {initval[29:0], periodic, en};
    endfunction

    task automatic add_step(input kind_e kind, input logic [13:0] addr, input logic [31:0] data,
                            input logic [31:0] mask, input logic [31:0] expected);
        steps.push_back('{kind, addr, data, mask, 1'b0, excp_pkg::ECODE_INT, 1'b0, expected});
    endtask

    task automatic add_commit(input logic [31:0] pc, input bit excp_valid,
                              input excp_pkg::ecode_e code, input bit is_ertn,
                              input logic [31:0] target);
        steps.push_back('{K_COMMIT, 14'h0, pc, ALL, excp_valid, code, is_ertn, target});
    endtask

    task automatic build_table();
        csr_pkg::u32_t v;
        // Reset value, write masks, unknown address
        add_step(K_READ, csr_pkg::CSR_CRMD, 0, ALL, CRMD_DA);
        add_step(K_WRITE, csr_pkg::CSR_EENTRY, ALL, 0, 0);
        add_step(K_READ, csr_pkg::CSR_EENTRY, 0, ALL, 32'hffff_ffc0);
        add_step(K_WRITE, csr_pkg::CSR_PRMD, ALL, 0, 0);
        add_step(K_READ, csr_pkg::CSR_PRMD, 0, ALL, 32'h7);
        add_step(K_WRITE, csr_pkg::CSR_SAVE0, ALL, 0, 0);
        add_step(K_READ, csr_pkg::CSR_SAVE0, 0, ALL, ALL);
        for (int i = 1; i < 4; i++) begin
            v = $urandom;
            add_step(K_WRITE, 14'h030 + 14'(i), v, 0, 0);
            add_step(K_READ, 14'h030 + 14'(i), 0, ALL, v);
        end
        add_step(K_READ, 14'h3ff, 0, ALL, 0);
        // One-shot timer counting down from 12
        add_step(K_WRITE, csr_pkg::CSR_TCFG, tcfg_word(3, 0, 1), 0, 0);
        add_step(K_READ, csr_pkg::CSR_TVAL, 0, ALL, 3 * 4);
        add_step(K_WAIT, 0, 11, 0, 0);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, TI_M, 0);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, TI_M, TI_M);
        add_step(K_READ, csr_pkg::CSR_TVAL, 0, ALL, ALL);
        add_step(K_WRITE, csr_pkg::CSR_TICLR, 1, 0, 0);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, TI_M, 0);
        // Periodic timer with a period of initval * 4 + 1 cycles
        add_step(K_WRITE, csr_pkg::CSR_TCFG, tcfg_word(2, 1, 1), 0, 0);
        add_step(K_WAIT, 0, 8, 0, 0);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, TI_M, 0);
        add_step(K_READ, csr_pkg::CSR_TVAL, 0, ALL, 2 * 4);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, TI_M, TI_M);
        add_step(K_WRITE, csr_pkg::CSR_TICLR, 1, 0, 0);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, TI_M, 0);
        add_step(K_WAIT, 0, 4, 0, 0);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, TI_M, 0);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, TI_M, TI_M);
        add_step(K_WRITE, csr_pkg::CSR_TCFG, 0, 0, 0);
        add_step(K_WRITE, csr_pkg::CSR_TICLR, 1, 0, 0);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, TI_M, 0);
        // Exception entry, return, BADV only for ADEF
        add_step(K_WRITE, csr_pkg::CSR_EENTRY, HANDLER, 0, 0);
        add_step(K_WRITE, csr_pkg::CSR_PRMD, 0, 0, 0);
        add_step(K_WRITE, csr_pkg::CSR_CRMD, CRMD_DA | CRMD_IE | PLV3, 0, 0);
        add_commit(32'h1c00_1234, 1, excp_pkg::ECODE_SYS, 0, HANDLER);
        add_step(K_READ, csr_pkg::CSR_ERA, 0, ALL, 32'h1c00_1234);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, ECODE_M, 32'h0b << 16);
        add_step(K_READ, csr_pkg::CSR_PRMD, 0, ALL, 32'h7);   // pplv 3, pie 1
        add_step(K_READ, csr_pkg::CSR_CRMD, 0, ALL, CRMD_DA);
        add_step(K_READ, csr_pkg::CSR_BADV, 0, ALL, 0);
        add_commit(32'h1c00_1300, 0, excp_pkg::ECODE_SYS, 1, 32'h1c00_1234);
        add_step(K_READ, csr_pkg::CSR_CRMD, 0, ALL, CRMD_DA | CRMD_IE | PLV3);
        add_commit(32'h1c00_1400, 1, excp_pkg::ECODE_ADEF, 0, HANDLER);
        add_step(K_READ, csr_pkg::CSR_BADV, 0, ALL, BAD_ADDR);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, ECODE_M, 32'h08 << 16);
        // Hardware interrupt beats the exception
        add_step(K_WRITE, csr_pkg::CSR_CRMD, CRMD_DA | CRMD_IE | PLV3, 0, 0);
        add_step(K_WRITE, csr_pkg::CSR_ECFG, 32'h4, 0, 0);
        add_step(K_HWINT, 0, 32'h01, 0, 0);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, 32'h3fc, 32'h4);
        add_commit(32'h1c00_2000, 1, excp_pkg::ECODE_SYS, 0, HANDLER);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, ECODE_M, 0);
        add_step(K_READ, csr_pkg::CSR_ERA, 0, ALL, 32'h1c00_2000);
        add_commit(32'h1c00_2100, 0, excp_pkg::ECODE_SYS, 1, 32'h1c00_2000);
        add_step(K_WRITE, csr_pkg::CSR_ECFG, 0, 0, 0);
        add_commit(32'h1c00_2000, 1, excp_pkg::ECODE_SYS, 0, HANDLER);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, ECODE_M, 32'h0b << 16);
        // Software interrupt
        add_step(K_HWINT, 0, 0, 0, 0);
        add_step(K_WRITE, csr_pkg::CSR_ESTAT, 32'h3, 0, 0);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, 32'h3ff, 32'h3);
        add_step(K_WRITE, csr_pkg::CSR_ECFG, 32'h1, 0, 0);
        add_step(K_WRITE, csr_pkg::CSR_CRMD, CRMD_DA | CRMD_IE | PLV3, 0, 0);
        add_commit(32'h1c00_3000, 0, excp_pkg::ECODE_SYS, 0, HANDLER);
        add_step(K_READ, csr_pkg::CSR_ESTAT, 0, ECODE_M, 0);
        add_step(K_READ, csr_pkg::CSR_ERA, 0, ALL, 32'h1c00_3000);
        add_step(K_READ, csr_pkg::CSR_CRMD, 0, ALL, CRMD_DA);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic apply_step(input step_t s);
        int waited;
        case (s.kind)
            K_WRITE: begin
                csr_op.we      = 1'b1;
                csr_op.addr    = csr_pkg::csr_addr_e'(s.addr);
                csr_op.wr_data = s.data;
                next_cycle();
                csr_op.we      = 1'b0;
            end
            K_READ: begin
                rd_addr  = csr_pkg::csr_addr_e'(s.addr);
                exp_val  = s.exp_val;
                exp_mask = s.mask;
                chk_rd   = 1'b1;
                next_cycle();
                chk_rd   = 1'b0;
            end
            K_COMMIT: begin
                commit.valid      = 1'b1;
                commit.pc         = s.data;
                commit.excp_valid = s.excp_valid;
                commit.excp_code  = s.code;
                commit.badv       = BAD_ADDR;
                commit.is_ertn    = s.is_ertn;
                next_cycle();
                commit.valid      = 1'b0;
                waited = 0;
                while (!redirect_valid && waited < REDIRECT_TIMEOUT) begin
                    next_cycle();
                    waited++;
                end
                if (!redirect_valid) begin
                    $display("Timeout at %0t: no redirect after the commit of pc %h",
                             $time, s.data);
                    timeouts++;
                end else begin
                    if (waited != 0) begin
                        $display("Redirect at %0t came %0d cycles late for the commit of pc %h",
                                 $time, waited, s.data);
                        late++;
                    end
                    exp_val   = s.exp_val;
                    chk_redir = 1'b1;
                    next_cycle();
                    chk_redir = 1'b0;
                end
            end
            K_WAIT: begin
                repeat (s.data) next_cycle();
            end
            default: begin
                hw_int = s.data[7:0];
                next_cycle();
            end
        endcase
    endtask

    initial begin
        void'($urandom(71627));
        rst_n     = 1'b0;
        csr_op    = '0;
        commit    = '0;
        hw_int    = '0;
        rd_addr   = csr_pkg::CSR_CRMD;
        chk_rd    = 1'b0;
        chk_redir = 1'b0;
        exp_val   = '0;
        exp_mask  = '0;
        timeouts  = 0;
        late      = 0;
        build_table();
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        next_cycle();
        $display("Errors: %0d (compare %0d, timeout %0d, late %0d)",
                 errors + timeouts + late, errors, timeouts, late);
        if (errors + timeouts + late == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
